// ==== hw/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data and address width.
`define CPU_WORD_BITS 8

// upper nibble of the opcode byte.
`define CPU_OPC_LSB 4
`define CPU_OPC_MOV 4'b0000
`define CPU_OPC_ADD 4'b0001
`define CPU_OPC_JMP 4'b1100

`define CPU_BYTE_NOP 8'hFE
`define CPU_BYTE_HLT 8'hFF

// operand fields need class bits 7:6 at 00.
`define CPU_CLASS_LSB 6
`define CPU_DST_LSB 2
`define CPU_SRC_LSB 0

`endif

// ==== hw/cpu_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_BITS-1:0] word_t;

  typedef enum logic [2:0] {
    reset,
    fetch_operation,
    decode,
    fetch_immediate,
    execute,
    write_register,
    write_memory
  } stage_e;

  typedef enum logic [2:0] {mov, add, jmp, nop, hlt} opcode_e;

  typedef enum logic [2:0] {reg_a, address_reg_a, address_imm, imm, unused} operand_e;

  typedef enum logic [1:0] {stay, read, write} mem_ctrl_e;

  typedef enum logic [1:0] {fop_idle, fop_begin, fop_end} fetch_op_e;

  typedef enum logic [3:0] {
    fimm_idle,
    fimm_begin,
    fimm_wait_imm,
    fimm_load_imm,
    fimm_wait_src_addr,
    fimm_load_src_addr,
    fimm_wait_src,
    fimm_load_src,
    fimm_wait_dst_addr,
    fimm_load_dst_addr,
    fimm_wait_dst,
    fimm_load_dst,
    fimm_end
  } fetch_imm_e;

  typedef enum logic [1:0] {wmem_idle, wmem_begin, wmem_end} write_mem_e;

  typedef struct packed {
    opcode_e  opcode;
    operand_e src;
    operand_e dst;
  } decoded_t;

  // words gathered during operand fetch.
  typedef struct packed {
    word_t imm;
    word_t src_addr;
    word_t mem_src;
    word_t dst_addr;
    word_t mem_dst;
  } operands_t;

  typedef struct packed {
    mem_ctrl_e ctrl;
    word_t     addr;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== hw/stage_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_control (
  input  logic              CLOCK,
  input  logic              RESET,
  input  logic              opcode_done,
  input  logic              operands_done,
  input  logic              write_done,
  input  cpu_pkg::decoded_t decoded,
  output cpu_pkg::stage_e   stage
);

  cpu_pkg::stage_e next_stage;

  always_comb begin
    next_stage = stage;
    case (stage)
      cpu_pkg::reset:           next_stage = cpu_pkg::fetch_operation;
      cpu_pkg::fetch_operation: if (opcode_done) next_stage = cpu_pkg::decode;
      cpu_pkg::decode:          next_stage = cpu_pkg::fetch_immediate;
      cpu_pkg::fetch_immediate: if (operands_done) next_stage = cpu_pkg::execute;
      cpu_pkg::execute: begin
        case (decoded.dst)
          cpu_pkg::reg_a:         next_stage = cpu_pkg::write_register;
          cpu_pkg::address_reg_a,
          cpu_pkg::address_imm:   next_stage = cpu_pkg::write_memory;
          default:                next_stage = cpu_pkg::fetch_operation; // no destination.
        endcase
      end
      cpu_pkg::write_register:  next_stage = cpu_pkg::fetch_operation;
      cpu_pkg::write_memory:    if (write_done) next_stage = cpu_pkg::fetch_operation;
      default:                  next_stage = cpu_pkg::fetch_operation;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage <= cpu_pkg::reset;
    end else begin
      stage <= next_stage;
    end
  end

endmodule

`default_nettype wire

// ==== hw/instruction_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module instruction_decoder (
  input  logic              CLOCK,
  input  logic              RESET,
  input  cpu_pkg::stage_e   stage,
  input  cpu_pkg::word_t    opcode_byte,
  output cpu_pkg::decoded_t decoded
);

  cpu_pkg::decoded_t next_decoded;
  logic [3:0]        opc_nibble;
  logic [1:0]        class_bits;
  logic [1:0]        dst_field;
  logic [1:0]        src_field;

  assign opc_nibble = opcode_byte[`CPU_OPC_LSB +: 4];
  assign class_bits = opcode_byte[`CPU_CLASS_LSB +: 2];
  assign dst_field  = opcode_byte[`CPU_DST_LSB +: 2];
  assign src_field  = opcode_byte[`CPU_SRC_LSB +: 2];

  always_comb begin
    next_decoded = decoded;
    if (stage == cpu_pkg::decode) begin
      next_decoded.src = cpu_pkg::unused;
      next_decoded.dst = cpu_pkg::unused;
      if (opcode_byte == `CPU_BYTE_NOP) begin
        next_decoded.opcode = cpu_pkg::nop;
      end else if (opcode_byte == `CPU_BYTE_HLT) begin
        next_decoded.opcode = cpu_pkg::hlt;
      end else begin
        case (opc_nibble)
          `CPU_OPC_MOV: next_decoded.opcode = cpu_pkg::mov;
          `CPU_OPC_ADD: next_decoded.opcode = cpu_pkg::add;
          `CPU_OPC_JMP: next_decoded.opcode = cpu_pkg::jmp;
          default:      next_decoded.opcode = cpu_pkg::hlt; // undefined byte.
        endcase
      end

      if (class_bits == 2'b00 && next_decoded.opcode != cpu_pkg::hlt) begin
        next_decoded.src = cpu_pkg::operand_e'(src_field);
        // 11 means no destination.
        if (dst_field != 2'b11) next_decoded.dst = cpu_pkg::operand_e'(dst_field);
      end else if (next_decoded.opcode == cpu_pkg::jmp) begin
        next_decoded.src = cpu_pkg::imm; // jump offset.
      end
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      decoded <= '{opcode: cpu_pkg::nop, src: cpu_pkg::unused, dst: cpu_pkg::unused};
    end else begin
      decoded <= next_decoded;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module fetch_unit (
  input  logic               CLOCK,
  input  logic               RESET,
  input  cpu_pkg::stage_e    stage,
  input  cpu_pkg::decoded_t  decoded,
  input  cpu_pkg::word_t     read_bus,
  input  cpu_pkg::word_t     accumulator,
  output cpu_pkg::mem_req_t  fetch_req,
  output cpu_pkg::word_t     opcode_byte,
  output cpu_pkg::operands_t operands,
  output logic               opcode_done,
  output logic               operands_done
);

  cpu_pkg::word_t     ip;
  cpu_pkg::fetch_op_e op_state;
  cpu_pkg::fetch_op_e next_op_state;
  cpu_pkg::fetch_imm_e imm_state;
  cpu_pkg::fetch_imm_e next_imm_state;
  logic               halted;

  function automatic cpu_pkg::fetch_imm_e dst_step(input cpu_pkg::operand_e dst);
    case (dst)
      cpu_pkg::address_imm:   return cpu_pkg::fimm_wait_dst_addr;
      cpu_pkg::address_reg_a: return cpu_pkg::fimm_wait_dst;
      default:                return cpu_pkg::fimm_end;
    endcase
  endfunction

  function automatic cpu_pkg::fetch_imm_e src_step(input cpu_pkg::decoded_t dec);
    case (dec.src)
      cpu_pkg::imm:           return cpu_pkg::fimm_wait_imm;
      cpu_pkg::address_imm:   return cpu_pkg::fimm_wait_src_addr;
      cpu_pkg::address_reg_a: return cpu_pkg::fimm_wait_src;
      default:                return dst_step(dec.dst);
    endcase
  endfunction

  assign halted        = (decoded.opcode == cpu_pkg::hlt);
  assign opcode_done   = (stage == cpu_pkg::fetch_operation) && (op_state == cpu_pkg::fop_end);
  assign operands_done = (stage == cpu_pkg::fetch_immediate) && (imm_state == cpu_pkg::fimm_end);

  always_comb begin
    next_op_state = cpu_pkg::fop_idle;
    if (stage == cpu_pkg::fetch_operation) begin
      case (op_state)
        cpu_pkg::fop_idle:  next_op_state = cpu_pkg::fop_begin;
        cpu_pkg::fop_begin: next_op_state = cpu_pkg::fop_end;
        default:            next_op_state = cpu_pkg::fop_idle;
      endcase
    end
  end

  always_comb begin
    next_imm_state = cpu_pkg::fimm_idle;
    if (stage == cpu_pkg::fetch_immediate) begin
      case (imm_state)
        cpu_pkg::fimm_idle:          next_imm_state = cpu_pkg::fimm_begin;
        cpu_pkg::fimm_begin:         next_imm_state = src_step(decoded);
        cpu_pkg::fimm_wait_imm:      next_imm_state = cpu_pkg::fimm_load_imm;
        cpu_pkg::fimm_wait_src_addr: next_imm_state = cpu_pkg::fimm_load_src_addr;
        cpu_pkg::fimm_load_src_addr: next_imm_state = cpu_pkg::fimm_wait_src;
        cpu_pkg::fimm_wait_src:      next_imm_state = cpu_pkg::fimm_load_src;
        cpu_pkg::fimm_load_imm,
        cpu_pkg::fimm_load_src:      next_imm_state = dst_step(decoded.dst);
        cpu_pkg::fimm_wait_dst_addr: next_imm_state = cpu_pkg::fimm_load_dst_addr;
        cpu_pkg::fimm_load_dst_addr: next_imm_state = cpu_pkg::fimm_wait_dst;
        cpu_pkg::fimm_wait_dst:      next_imm_state = cpu_pkg::fimm_load_dst;
        cpu_pkg::fimm_load_dst:      next_imm_state = cpu_pkg::fimm_end;
        default:                     next_imm_state = cpu_pkg::fimm_idle;
      endcase
    end
  end

  // read data shows up one cycle after the address.
  always_comb begin
    fetch_req = '{ctrl: cpu_pkg::stay, addr: '0};
    if (stage == cpu_pkg::fetch_operation) begin
      fetch_req = '{ctrl: cpu_pkg::read, addr: ip};
    end else if (stage == cpu_pkg::fetch_immediate) begin
      case (imm_state)
        cpu_pkg::fimm_wait_imm, cpu_pkg::fimm_load_imm,
        cpu_pkg::fimm_wait_src_addr, cpu_pkg::fimm_load_src_addr,
        cpu_pkg::fimm_wait_dst_addr, cpu_pkg::fimm_load_dst_addr:
          fetch_req = '{ctrl: cpu_pkg::read, addr: ip};
        cpu_pkg::fimm_wait_src, cpu_pkg::fimm_load_src:
          fetch_req = '{ctrl: cpu_pkg::read, addr: (decoded.src == cpu_pkg::address_reg_a) ?
                                                   accumulator : operands.src_addr};
        cpu_pkg::fimm_wait_dst, cpu_pkg::fimm_load_dst:
          fetch_req = '{ctrl: cpu_pkg::read, addr: (decoded.dst == cpu_pkg::address_reg_a) ?
                                                   accumulator : operands.dst_addr};
        default: fetch_req = '{ctrl: cpu_pkg::stay, addr: '0};
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      ip        <= '0;
      op_state  <= cpu_pkg::fop_idle;
      imm_state <= cpu_pkg::fimm_idle;
    end else begin
      op_state  <= next_op_state;
      imm_state <= next_imm_state;
      if (!halted) begin // hlt freezes ip.
        if (stage == cpu_pkg::fetch_immediate) begin
          case (imm_state)
            cpu_pkg::fimm_idle,
            cpu_pkg::fimm_load_imm,
            cpu_pkg::fimm_load_src_addr,
            cpu_pkg::fimm_load_dst_addr: ip <= ip + `CPU_WORD_BITS'd1; // past opcode or byte.
            default: ;
          endcase
        end else if (stage == cpu_pkg::execute && decoded.opcode == cpu_pkg::jmp) begin
          ip <= ip + operands.imm; // relative to byte after offset.
        end
      end
    end
  end

  always_ff @(posedge CLOCK) begin
    if (stage == cpu_pkg::fetch_operation && op_state == cpu_pkg::fop_begin) begin
      opcode_byte <= read_bus;
    end
    if (stage == cpu_pkg::fetch_immediate) begin
      case (imm_state)
        cpu_pkg::fimm_load_imm:      operands.imm      <= read_bus;
        cpu_pkg::fimm_load_src_addr: operands.src_addr <= read_bus;
        cpu_pkg::fimm_load_src:      operands.mem_src  <= read_bus;
        cpu_pkg::fimm_load_dst_addr: operands.dst_addr <= read_bus;
        cpu_pkg::fimm_load_dst:      operands.mem_dst  <= read_bus;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  logic               CLOCK,
  input  logic               RESET,
  input  cpu_pkg::stage_e    stage,
  input  cpu_pkg::decoded_t  decoded,
  input  cpu_pkg::operands_t operands,
  output cpu_pkg::word_t     result,
  output cpu_pkg::word_t     accumulator
);

  cpu_pkg::word_t src_value;
  cpu_pkg::word_t dst_value;

  always_comb begin
    case (decoded.src)
      cpu_pkg::reg_a:         src_value = accumulator;
      cpu_pkg::address_reg_a,
      cpu_pkg::address_imm:   src_value = operands.mem_src;
      cpu_pkg::imm:           src_value = operands.imm;
      default:                src_value = '0;
    endcase
  end

  // value at the destination before the instruction.
  always_comb begin
    case (decoded.dst)
      cpu_pkg::reg_a:         dst_value = accumulator;
      cpu_pkg::address_reg_a,
      cpu_pkg::address_imm:   dst_value = operands.mem_dst;
      default:                dst_value = '0;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (stage == cpu_pkg::execute) begin
      case (decoded.opcode)
        cpu_pkg::add: result <= dst_value + src_value; // wraps at 8 bits.
        cpu_pkg::mov: result <= src_value;
        default:      result <= dst_value;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      accumulator <= '0;
    end else if (stage == cpu_pkg::write_register) begin
      accumulator <= result;
    end
  end

endmodule

`default_nettype wire

// ==== hw/memory_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_port (
  input  logic               CLOCK,
  input  logic               RESET,
  input  cpu_pkg::stage_e    stage,
  input  cpu_pkg::mem_req_t  fetch_req,
  input  cpu_pkg::operand_e  dst,
  input  cpu_pkg::word_t     accumulator,
  input  cpu_pkg::word_t     dst_addr,
  input  cpu_pkg::word_t     result,
  output cpu_pkg::mem_ctrl_e ctrl_bus,
  output cpu_pkg::word_t     addr_bus,
  output cpu_pkg::word_t     write_bus,
  output logic               write_done
);

  cpu_pkg::write_mem_e wr_state;
  cpu_pkg::write_mem_e next_wr_state;
  cpu_pkg::word_t      write_addr;

  assign write_addr = (dst == cpu_pkg::address_reg_a) ? accumulator : dst_addr;
  assign write_done = (stage == cpu_pkg::write_memory) && (wr_state == cpu_pkg::wmem_end);

  always_comb begin
    next_wr_state = cpu_pkg::wmem_idle;
    if (stage == cpu_pkg::write_memory) begin
      case (wr_state)
        cpu_pkg::wmem_idle:  next_wr_state = cpu_pkg::wmem_begin;
        cpu_pkg::wmem_begin: next_wr_state = cpu_pkg::wmem_end;
        default:             next_wr_state = cpu_pkg::wmem_idle;
      endcase
    end
  end

  always_comb begin
    ctrl_bus = cpu_pkg::stay;
    addr_bus = '0;
    case (stage)
      cpu_pkg::fetch_operation,
      cpu_pkg::fetch_immediate: begin
        ctrl_bus = fetch_req.ctrl;
        addr_bus = fetch_req.addr;
      end
      cpu_pkg::write_memory: begin
        addr_bus = write_addr;
        // write held two cycles.
        if (wr_state != cpu_pkg::wmem_idle) ctrl_bus = cpu_pkg::write;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      wr_state  <= cpu_pkg::wmem_idle;
      write_bus <= '0;
    end else begin
      wr_state <= next_wr_state;
      if (stage == cpu_pkg::write_memory && wr_state == cpu_pkg::wmem_idle) begin
        write_bus <= result; // stable before write starts.
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic              CLOCK,
  input  logic              RESET,
  input  cpu_pkg::word_t    read_bus,
  output cpu_pkg::mem_ctrl_e ctrl_bus,
  output cpu_pkg::word_t    addr_bus,
  output cpu_pkg::word_t    write_bus,
  output cpu_pkg::word_t    out
);

  cpu_pkg::stage_e    stage;
  cpu_pkg::decoded_t  decoded;
  cpu_pkg::operands_t operands;
  cpu_pkg::mem_req_t  fetch_req;
  cpu_pkg::word_t     opcode_byte;
  cpu_pkg::word_t     result;
  logic               opcode_done;
  logic               operands_done;
  logic               write_done;

  stage_control stage_control_i (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .opcode_done   (opcode_done),
    .operands_done (operands_done),
    .write_done    (write_done),
    .decoded       (decoded),
    .stage         (stage)
  );

  instruction_decoder instruction_decoder_i (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .stage       (stage),
    .opcode_byte (opcode_byte),
    .decoded     (decoded)
  );

  fetch_unit fetch_unit_i (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .stage         (stage),
    .decoded       (decoded),
    .read_bus      (read_bus),
    .accumulator   (out),
    .fetch_req     (fetch_req),
    .opcode_byte   (opcode_byte),
    .operands      (operands),
    .opcode_done   (opcode_done),
    .operands_done (operands_done)
  );

  execute_unit execute_unit_i (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .stage       (stage),
    .decoded     (decoded),
    .operands    (operands),
    .result      (result),
    .accumulator (out)
  );

  memory_port memory_port_i (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .stage       (stage),
    .fetch_req   (fetch_req),
    .dst         (decoded.dst),
    .accumulator (out),
    .dst_addr    (operands.dst_addr),
    .result      (result),
    .ctrl_bus    (ctrl_bus),
    .addr_bus    (addr_bus),
    .write_bus   (write_bus),
    .write_done  (write_done)
  );

endmodule

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  localparam int NUM_ROWS        = 12;
  localparam int CLOCK_PERIOD    = 4;
  localparam int RESET_CYCLES    = 3;
  localparam int MAX_INSN_CYCLES = 19;
  localparam int HALT_CYCLES     = 40;
  localparam int DATA_BASE       = 128;

  // program bytes load from address 0, data bytes from DATA_BASE.
  typedef struct packed {
    logic [15:0][7:0] prog;
    logic [3:0][7:0]  data;
    logic [7:0]       budget;
    logic [7:0]       exp_out;
    logic [7:0]       exp_addr;
    logic [7:0]       exp_byte;
  } row_t;

  logic               CLOCK;
  logic               RESET = 1'b1;
  cpu_pkg::word_t     read_bus = '0;
  cpu_pkg::mem_ctrl_e ctrl_bus;
  cpu_pkg::word_t     addr_bus;
  cpu_pkg::word_t     write_bus;
  cpu_pkg::word_t     out;

  logic [7:0] mem [256];
  logic [7:0] image [256];
  row_t       rows [NUM_ROWS];
  int         write_count = 0;
  int         errors = 0;
  int         checks = 0;
  logic       table_ready = 1'b0;

  cpu cpu_i (
    .CLOCK     (CLOCK),
    .RESET     (RESET),
    .read_bus  (read_bus),
    .ctrl_bus  (ctrl_bus),
    .addr_bus  (addr_bus),
    .write_bus (write_bus),
    .out       (out)
  );

  initial begin
    CLOCK = 1'b0;
    forever #(CLOCK_PERIOD / 2) CLOCK = ~CLOCK;
  end

  // read data one cycle after the address.
  always @(posedge CLOCK) begin : memory_model
    cpu_pkg::word_t     req_addr;
    cpu_pkg::mem_ctrl_e req_ctrl;
    cpu_pkg::word_t     req_data;
    logic               req_reset;
    int                 i;
    req_addr  = addr_bus;
    req_ctrl  = ctrl_bus;
    req_data  = write_bus;
    req_reset = RESET;
    #1;
    if (req_ctrl == cpu_pkg::write) begin
      mem[req_addr] = req_data;
      write_count = write_count + 1;
    end
    if (req_reset) begin
      for (i = 0; i < 256; i++) begin
        mem[i] = image[i]; // reload while in reset.
      end
    end
    read_bus = mem[req_addr];
  end

  function automatic row_t make_row(input logic [63:0] prog8, input logic [31:0] data4,
                                    input int budget, input logic [7:0] exp_out,
                                    input logic [7:0] exp_addr, input logic [7:0] exp_byte);
    row_t row;
    int   k;
    for (k = 0; k < 16; k++) begin
      row.prog[k] = (k < 8) ? prog8[63 - 8 * k -: 8] : 8'hFF;
    end
    for (k = 0; k < 4; k++) begin
      row.data[k] = data4[31 - 8 * k -: 8];
    end
    row.budget   = budget[7:0];
    row.exp_out  = exp_out;
    row.exp_addr = exp_addr;
    row.exp_byte = exp_byte;
    return row;
  endfunction

  // opcode byte is 0 for mov, 1 for add in the upper nibble, dst in 3:2, src in 1:0.
  task automatic fill_table();
    rows[0]  = make_row(64'h03_5A_FF_FF_FF_FF_FF_FF, 32'h11223344, 3, 8'h5A, 8'h80, 8'h11);
    rows[1]  = make_row(64'h03_F0_13_25_FF_FF_FF_FF, 32'h11223344, 4, 8'h15, 8'h80, 8'h11);
    rows[2]  = make_row(64'h03_10_12_81_FF_FF_FF_FF, 32'h11F73344, 4, 8'h07, 8'h81, 8'hF7);
    rows[3]  = make_row(64'h03_82_11_FF_FF_FF_FF_FF, 32'h11229044, 4, 8'h12, 8'h82, 8'h90);
    rows[4]  = make_row(64'h03_21_10_FF_FF_FF_FF_FF, 32'h11223344, 4, 8'h42, 8'h80, 8'h11);
    // memory destinations.
    rows[5]  = make_row(64'h03_3C_08_83_FF_FF_FF_FF, 32'h11223344, 4, 8'h3C, 8'h83, 8'h3C);
    rows[6]  = make_row(64'h1B_05_81_FF_FF_FF_FF_FF, 32'h11FD3344, 3, 8'h00, 8'h81, 8'h02);
    rows[7]  = make_row(64'h03_82_07_C3_FF_FF_FF_FF, 32'h11223344, 4, 8'h82, 8'h82, 8'hC3);
    rows[8]  = make_row(64'h03_80_17_90_FF_FF_FF_FF, 32'h7F223344, 4, 8'h80, 8'h80, 8'h0F);
    // jmp skips the mov of 99.
    rows[9]  = make_row(64'h03_11_C0_02_03_99_FF_FF, 32'h11223344, 4, 8'h11, 8'h80, 8'h11);
    rows[10] = make_row(64'h03_44_FE_FE_13_01_FF_FF, 32'h11223344, 6, 8'h45, 8'h80, 8'h11);
    rows[11] = make_row(64'h03_66_80_03_77_FF_FF_FF, 32'h11223344, 4, 8'h66, 8'h80, 8'h11);
  endtask

  task automatic build_image(input row_t row);
    int i;
    for (i = 0; i < 256; i++) begin
      image[i] = i[7:0] ^ 8'hA5;
    end
    for (i = 0; i < 16; i++) begin
      image[i] = row.prog[i];
    end
    for (i = 0; i < 4; i++) begin
      image[DATA_BASE + i] = row.data[i];
    end
  endtask

  task automatic check_memory(input int r);
    int         i;
    logic [7:0] expected;
    for (i = 0; i < 256; i++) begin
      expected = (i == int'(rows[r].exp_addr)) ? rows[r].exp_byte : image[i];
      checks++;
      if (mem[i] != expected) begin
        errors++;
        $display("FAILED row %0d: mem[%h] = %h, expected %h", r, i[7:0], mem[i], expected);
      end
    end
  endtask

  task automatic run_row(input int r);
    int writes_at_halt;
    build_image(rows[r]);
    @(posedge CLOCK);
    #1 RESET = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLOCK);
    #1 RESET = 1'b0;
    repeat (int'(rows[r].budget) * MAX_INSN_CYCLES) @(posedge CLOCK);
    @(negedge CLOCK);
    checks++;
    if (out != rows[r].exp_out) begin
      errors++;
      $display("FAILED row %0d: out = %h, expected %h", r, out, rows[r].exp_out);
    end
    check_memory(r);
    writes_at_halt = write_count;
    repeat (HALT_CYCLES) @(posedge CLOCK); // still halted.
    @(negedge CLOCK);
    checks++;
    if (out != rows[r].exp_out) begin
      errors++;
      $display("FAILED row %0d: out = %h after halt, expected %h", r, out, rows[r].exp_out);
    end
    checks++;
    if (write_count != writes_at_halt) begin
      errors++;
      $display("FAILED row %0d: write_count = %h after halt, expected %h",
               r, write_count, writes_at_halt);
    end
  endtask

  initial begin : main
    int r;
    fill_table();
    table_ready = 1'b1;
    for (r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int total_cycles;
    int r;
    wait (table_ready);
    total_cycles = 0;
    for (r = 0; r < NUM_ROWS; r++) begin
      total_cycles += int'(rows[r].budget) * MAX_INSN_CYCLES + RESET_CYCLES + HALT_CYCLES + 3;
    end
    total_cycles = total_cycles * 2;
    #(total_cycles * CLOCK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", total_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/stage_control.sv
hw/instruction_decoder.sv
hw/fetch_unit.sv
hw/execute_unit.sv
hw/memory_port.sv
hw/cpu.sv
testbench/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
RTL_TOP   ?= cpu
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= STATUS: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# run the testbench and fail unless the pass line shows up.
sim: build
	@result="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
